// ==== design/uart_params.svh ====
`ifndef UART_PARAMS_SVH
`define UART_PARAMS_SVH

// Data path widths
`define UART_DATA_W 8
`define UART_DIV_W 16
`define UART_ADDR_W 3

// Entries per FIFO
`define UART_FIFO_DEPTH 4

// Clock cycles per bit out of reset
`define UART_DIV_RESET 8

// Register map
`define UART_ADDR_TXDATA 0
`define UART_ADDR_RXDATA 1
`define UART_ADDR_STATUS 2
`define UART_ADDR_DIVISOR 3

`endif

// ==== design/uart_pkg.sv ====
`include "uart_params.svh"

package uart_pkg;

  // One byte of serial or bus data
  typedef logic [`UART_DATA_W-1:0] data_t;

  // Clock cycles per serial bit
  typedef logic [`UART_DIV_W-1:0] div_t;

  // Register address
  typedef logic [`UART_ADDR_W-1:0] addr_t;

  // Bus access states
  typedef enum logic [2:0] {
    IDLE   = 3'd0,
    READ   = 3'd1,
    WRITE  = 3'd2,
    END_OP = 3'd3,
    FINAL  = 3'd4
  } fsm_state_t;

  // Low nibble of the STATUS register
  typedef struct packed {
    logic tx_full;
    logic tx_empty;
    logic rx_empty;
    logic rx_overrun;
  } status_t;

endpackage

// ==== design/uart_fifo.sv ====
`timescale 1ns/1ps

module uart_fifo #(
  parameter int DEPTH = 4
) (
  input  logic            clock,
  input  logic            reset,
  input  logic            push,
  input  uart_pkg::data_t push_data,
  input  logic            pop,
  output uart_pkg::data_t pop_data,
  output logic            full,
  output logic            empty
);
  import uart_pkg::*;

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  data_t            mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  assign full    = (count == CNT_W'(DEPTH));
  assign empty   = (count == '0);
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  always_ff @(posedge clock) begin
    if (do_push) mem[wr_ptr] <= push_data;
    if (do_pop) pop_data <= mem[rd_ptr];
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_pop) rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
    end
  end

endmodule

// ==== design/uart_fsm.sv ====
`timescale 1ns/1ps
`include "uart_params.svh"

module uart_fsm (
  input  logic            clock,
  input  logic            reset,
  input  logic            rd_en,
  input  logic            wr_en,
  input  uart_pkg::addr_t addr,
  output logic            op,
  output logic            ack,
  output logic            bank_rd_en,
  output logic            bank_wr_en,
  output logic            rxdata_wr_en,
  output logic            tx_fifo_wr_en,
  output logic            rx_fifo_rd_en
);
  import uart_pkg::*;

  fsm_state_t present_state;
  fsm_state_t next_state;
  logic       rd_q;
  logic       wr_q;
  logic       read_active;
  logic       write_active;
  logic       end_rd;
  logic       end_wr;

  function automatic logic is_txdata(input addr_t a);
    return a == addr_t'(`UART_ADDR_TXDATA);
  endfunction

  function automatic logic is_rxdata(input addr_t a);
    return a == addr_t'(`UART_ADDR_RXDATA);
  endfunction

  // Data accesses take the extra END_OP step for the FIFO handoff
  function automatic fsm_state_t step(input fsm_state_t state, input logic rd,
                                      input logic wr, input addr_t a);
    fsm_state_t nxt;
    nxt = IDLE;
    case (state)
      IDLE: begin
        if (rd) nxt = READ;
        else if (wr) nxt = WRITE;
      end
      READ:    nxt = is_rxdata(a) ? END_OP : FINAL;
      WRITE:   nxt = is_txdata(a) ? END_OP : FINAL;
      END_OP:  nxt = FINAL;
      default: nxt = IDLE;
    endcase
    return nxt;
  endfunction

  // Strobes are captured first and seen by IDLE a cycle later
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      rd_q <= 1'b0;
      wr_q <= 1'b0;
    end else begin
      rd_q <= rd_en;
      wr_q <= wr_en;
    end
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) present_state <= IDLE;
    else present_state <= next_state;
  end

  always_comb begin
    next_state = step(present_state, rd_q, wr_q, addr);
  end

  // Outputs follow the state being entered
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      op           <= 1'b0;
      ack          <= 1'b0;
      read_active  <= 1'b0;
      write_active <= 1'b0;
      end_rd       <= 1'b0;
      end_wr       <= 1'b0;
    end else begin
      op           <= (next_state == READ) || (next_state == WRITE) ||
                      (next_state == END_OP);
      ack          <= (next_state == FINAL);
      read_active  <= (next_state == READ);
      write_active <= (next_state == WRITE);
      end_rd       <= (next_state == END_OP) && read_active && is_rxdata(addr);
      end_wr       <= (next_state == END_OP) && write_active && is_txdata(addr);
    end
  end

  assign bank_rd_en    = read_active;
  assign bank_wr_en    = write_active;
  assign rxdata_wr_en  = end_rd;
  assign tx_fifo_wr_en = end_wr;
  assign rx_fifo_rd_en = read_active && is_rxdata(addr);

endmodule

// ==== design/uart_bank.sv ====
`timescale 1ns/1ps
`include "uart_params.svh"

module uart_bank (
  input  logic              clock,
  input  logic              reset,
  input  uart_pkg::addr_t   addr,
  input  uart_pkg::data_t   wdata,
  input  logic              bank_rd_en,
  input  logic              bank_wr_en,
  input  logic              rxdata_wr_en,
  input  uart_pkg::data_t   rx_fifo_data,
  input  uart_pkg::status_t status,
  input  logic              rx_drop,
  output uart_pkg::div_t    divisor,
  output uart_pkg::data_t   rdata
);
  import uart_pkg::*;

  data_t   rx_reg;
  logic    rx_overrun;
  logic    rx_was_empty;
  logic    status_rd_q;
  status_t status_word;

  assign status_word.tx_full    = status.tx_full;
  assign status_word.tx_empty   = status.tx_empty;
  assign status_word.rx_empty   = status.rx_empty;
  assign status_word.rx_overrun = rx_overrun;

  // Pop result lands a cycle after the read strobe
  always_ff @(posedge clock) begin
    if (rxdata_wr_en) rx_reg <= rx_was_empty ? '0 : rx_fifo_data;
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      divisor      <= div_t'(`UART_DIV_RESET);
      rx_overrun   <= 1'b0;
      rx_was_empty <= 1'b1;
      status_rd_q  <= 1'b0;
    end else begin
      if (bank_wr_en && addr == addr_t'(`UART_ADDR_DIVISOR)) begin
        divisor <= div_t'(wdata);
      end
      // FIFO state at the moment of the pop
      if (bank_rd_en) rx_was_empty <= status.rx_empty;
      status_rd_q <= bank_rd_en && addr == addr_t'(`UART_ADDR_STATUS);
      // Cleared once the STATUS ack cycle is over, new drops win
      if (rx_drop) rx_overrun <= 1'b1;
      else if (status_rd_q) rx_overrun <= 1'b0;
    end
  end

  always_comb begin
    case (addr)
      addr_t'(`UART_ADDR_RXDATA):  rdata = rx_reg;
      addr_t'(`UART_ADDR_STATUS):  rdata = data_t'(status_word);
      addr_t'(`UART_ADDR_DIVISOR): rdata = divisor[`UART_DATA_W-1:0];
      default:                     rdata = '0;
    endcase
  end

endmodule

// ==== design/uart_baud_timer.sv ====
`timescale 1ns/1ps
`include "uart_params.svh"

module uart_baud_timer (
  input  logic           clock,
  input  logic           reset,
  input  uart_pkg::div_t divisor,
  input  logic           rx_start,
  output logic           tx_tick,
  output logic           rx_tick
);
  import uart_pkg::*;

  div_t tx_count;
  div_t rx_count;
  div_t half_period;

  assign half_period = divisor >> 1;
  assign tx_tick     = (tx_count == '0);
  assign rx_tick     = (rx_count == '0);

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      tx_count <= div_t'(`UART_DIV_RESET - 1);
      rx_count <= div_t'(`UART_DIV_RESET - 1);
    end else begin
      if (tx_tick) tx_count <= divisor - 1'b1;
      else tx_count <= tx_count - 1'b1;
      // Realign to mid-bit of the incoming start bit
      if (rx_start) rx_count <= (half_period == '0) ? '0 : half_period - 1'b1;
      else if (rx_tick) rx_count <= divisor - 1'b1;
      else rx_count <= rx_count - 1'b1;
    end
  end

endmodule

// ==== design/uart_phy.sv ====
`timescale 1ns/1ps
`include "uart_params.svh"

module uart_phy (
  input  logic            clock,
  input  logic            reset,
  input  logic            tx_tick,
  input  logic            rx_tick,
  input  logic            tx_empty,
  output logic            tx_pop,
  input  uart_pkg::data_t tx_data,
  output logic            txd,
  input  logic            rxd,
  output logic            rx_start,
  output logic            rx_push,
  output uart_pkg::data_t rx_data
);
  import uart_pkg::*;

  localparam logic [3:0] STOP_BIT  = 4'd8;
  localparam logic [3:0] FRAME_END = 4'd9;

  logic       tx_busy;
  logic       tx_load;
  logic [3:0] tx_count;
  data_t      tx_shift;
  logic       tx_frame_end;

  logic       rxd_meta;
  logic       rxd_sync;
  logic       rxd_prev;
  logic       rx_busy;
  logic [3:0] rx_count;

  // Next frame may start right as the stop bit ends
  assign tx_frame_end = tx_busy && (tx_count == FRAME_END);
  assign tx_pop       = tx_tick && !tx_empty && (!tx_busy || tx_frame_end);

  always_ff @(posedge clock) begin
    if (tx_load) tx_shift <= tx_data;
    else if (tx_tick && tx_busy && tx_count < STOP_BIT) tx_shift <= tx_shift >> 1;
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      tx_busy  <= 1'b0;
      tx_load  <= 1'b0;
      tx_count <= '0;
      txd      <= 1'b1;
    end else begin
      tx_load <= tx_pop;
      if (tx_pop) begin
        // Start bit while the popped byte arrives
        tx_busy  <= 1'b1;
        tx_count <= '0;
        txd      <= 1'b0;
      end else if (tx_tick && tx_busy) begin
        if (tx_frame_end) begin
          tx_busy <= 1'b0;
        end else begin
          txd      <= (tx_count == STOP_BIT) ? 1'b1 : tx_shift[0];
          tx_count <= tx_count + 4'd1;
        end
      end
    end
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      rxd_meta <= 1'b1;
      rxd_sync <= 1'b1;
      rxd_prev <= 1'b1;
    end else begin
      rxd_meta <= rxd;
      rxd_sync <= rxd_meta;
      rxd_prev <= rxd_sync;
    end
  end

  assign rx_start = !rx_busy && rxd_prev && !rxd_sync;

  // LSB first
  always_ff @(posedge clock) begin
    if (rx_tick && rx_busy && rx_count != '0 && rx_count != FRAME_END) begin
      rx_data <= {rxd_sync, rx_data[`UART_DATA_W-1:1]};
    end
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      rx_busy  <= 1'b0;
      rx_count <= '0;
      rx_push  <= 1'b0;
    end else begin
      rx_push <= 1'b0;
      if (rx_start) begin
        rx_busy  <= 1'b1;
        rx_count <= '0;
      end else if (rx_tick && rx_busy) begin
        if (rx_count == '0 && rxd_sync) begin
          // line back high at mid start bit, glitch
          rx_busy <= 1'b0;
        end else if (rx_count == FRAME_END) begin
          rx_busy <= 1'b0;
          rx_push <= rxd_sync;
        end else begin
          rx_count <= rx_count + 4'd1;
        end
      end
    end
  end

endmodule

// ==== design/uart_top.sv ====
`timescale 1ns/1ps
`include "uart_params.svh"

module uart_top (
  input  logic            clock,
  input  logic            reset,
  input  logic            rd_en,
  input  logic            wr_en,
  input  uart_pkg::addr_t addr,
  input  uart_pkg::data_t wdata,
  output uart_pkg::data_t rdata,
  output logic            op,
  output logic            ack,
  output logic            txd,
  input  logic            rxd
);
  import uart_pkg::*;

  logic    bank_rd_en;
  logic    bank_wr_en;
  logic    rxdata_wr_en;
  logic    tx_fifo_wr_en;
  logic    rx_fifo_rd_en;
  logic    tx_pop;
  logic    tx_full;
  logic    tx_empty;
  logic    rx_full;
  logic    rx_empty;
  logic    rx_push;
  logic    rx_start;
  logic    rx_drop;
  logic    tx_tick;
  logic    rx_tick;
  data_t   tx_data;
  data_t   rx_data;
  data_t   rx_fifo_data;
  div_t    divisor;
  status_t fifo_status;

  // Overrun is tracked inside the bank
  assign fifo_status.tx_full    = tx_full;
  assign fifo_status.tx_empty   = tx_empty;
  assign fifo_status.rx_empty   = rx_empty;
  assign fifo_status.rx_overrun = 1'b0;
  assign rx_drop                = rx_push && rx_full;

  uart_fsm fsm (
    .clock, .reset, .rd_en, .wr_en, .addr, .op, .ack,
    .bank_rd_en, .bank_wr_en, .rxdata_wr_en, .tx_fifo_wr_en, .rx_fifo_rd_en
  );

  uart_bank bank (
    .clock, .reset, .addr, .wdata, .bank_rd_en, .bank_wr_en, .rxdata_wr_en,
    .rx_fifo_data, .status(fifo_status), .rx_drop, .divisor, .rdata
  );

  uart_fifo #(.DEPTH(`UART_FIFO_DEPTH)) tx_fifo (
    .clock, .reset, .push(tx_fifo_wr_en), .push_data(wdata),
    .pop(tx_pop), .pop_data(tx_data), .full(tx_full), .empty(tx_empty)
  );

  uart_fifo #(.DEPTH(`UART_FIFO_DEPTH)) rx_fifo (
    .clock, .reset, .push(rx_push), .push_data(rx_data),
    .pop(rx_fifo_rd_en), .pop_data(rx_fifo_data), .full(rx_full), .empty(rx_empty)
  );

  uart_baud_timer baud_timer (
    .clock, .reset, .divisor, .rx_start, .tx_tick, .rx_tick
  );

  uart_phy phy (
    .clock, .reset, .tx_tick, .rx_tick, .tx_empty, .tx_pop, .tx_data, .txd,
    .rxd, .rx_start, .rx_push, .rx_data
  );

endmodule

// ==== dv/uart_assert.sv ====
`timescale 1ns/1ps
`include "uart_params.svh"

module uart_assert (
  input logic            clock,
  input logic            reset,
  input logic            rd_en,
  input logic            wr_en,
  input uart_pkg::addr_t addr,
  input logic            op,
  input logic            ack,
  input logic            txd,
  input logic            tx_tick
);
  import uart_pkg::*;

  int         fail_count = 0;
  logic       txd_q;
  logic       framing;
  logic [3:0] bit_idx;
  logic       data_access;

  // RXDATA reads and TXDATA writes pass through END_OP
  assign data_access = (rd_en && addr == addr_t'(`UART_ADDR_RXDATA)) ||
                       (wr_en && addr == addr_t'(`UART_ADDR_TXDATA));

  // Bit position of the frame on txd with 9 as the stop bit
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      txd_q   <= 1'b1;
      framing <= 1'b0;
      bit_idx <= '0;
    end else begin
      txd_q <= txd;
      if (!framing && txd_q && !txd) begin
        framing <= 1'b1;
        bit_idx <= '0;
      end else if (framing && tx_tick) begin
        if (bit_idx == 4'd9) framing <= 1'b0;
        else bit_idx <= bit_idx + 4'd1;
      end
    end
  end

  data_ack_latency: assert property (@(posedge clock) disable iff (reset)
    data_access |=> !ack ##1 !ack ##1 !ack ##1 ack)
    else begin
      $error("ack not 3 cycles after a data access");
      fail_count++;
    end

  reg_ack_latency: assert property (@(posedge clock) disable iff (reset)
    (rd_en || wr_en) && !data_access |=> !ack ##1 !ack ##1 ack)
    else begin
      $error("ack not 2 cycles after a register access");
      fail_count++;
    end

  ack_one_cycle: assert property (@(posedge clock) disable iff (reset) ack |=> !ack)
    else begin
      $error("ack longer than one cycle");
      fail_count++;
    end

  op_until_ack: assert property (@(posedge clock) disable iff (reset)
    op && !ack |=> op || ack)
    else begin
      $error("op dropped before ack");
      fail_count++;
    end

  // Sampled mid-cycle, after the first reset edge has settled the outputs
  quiet_in_reset: assert property (@(negedge clock) reset |-> !op && !ack)
    else begin
      $error("op or ack high during reset");
      fail_count++;
    end

  stop_bit_high: assert property (@(posedge clock) disable iff (reset)
    framing && bit_idx == 4'd9 |-> txd)
    else begin
      $error("txd low inside the stop bit");
      fail_count++;
    end

endmodule

bind uart_top uart_assert checks (
  .clock, .reset, .rd_en, .wr_en, .addr, .op, .ack, .txd, .tx_tick
);

// ==== dv/uart_tb.sv ====
`timescale 1ns/1ps
`include "uart_params.svh"

module uart_tb;
  import uart_pkg::*;

  localparam int    CLK_PERIOD   = 10;
  localparam int    LOOP_DIV     = 12;
  localparam int    FULL_DIV     = 100;
  localparam int    RX_DIV       = 16;
  localparam int    LOOP_BYTES   = 4;
  localparam int    FULL_BYTES   = 8;
  localparam int    RX_FRAMES    = 6;
  localparam int    ACK_LIMIT    = 16;
  localparam int    POLL_LIMIT   = 2000;
  localparam int    TX_FULL_BIT  = 3;
  localparam int    TX_EMPTY_BIT = 2;
  localparam int    RX_EMPTY_BIT = 1;
  localparam addr_t TXDATA       = addr_t'(`UART_ADDR_TXDATA);
  localparam addr_t RXDATA       = addr_t'(`UART_ADDR_RXDATA);
  localparam addr_t STATUS       = addr_t'(`UART_ADDR_STATUS);
  localparam addr_t DIVISOR      = addr_t'(`UART_ADDR_DIVISOR);
  // Twice the 10-bit time of every frame plus slack for setup and polling
  localparam int WATCHDOG_CYCLES =
    2 * 10 * (LOOP_BYTES * LOOP_DIV + FULL_BYTES * FULL_DIV + RX_FRAMES * RX_DIV) + 2000;

  logic        clock;
  logic        reset;
  logic        rd_en;
  logic        wr_en;
  addr_t       addr;
  data_t       wdata;
  data_t       rdata;
  logic        op;
  logic        ack;
  logic        txd;
  logic        rxd;
  logic        loop_back;
  logic        rxd_drive;
  logic [15:0] lfsr_state;
  int          errors;
  data_t       got;
  data_t       expected_q[$];

  uart_top DUT (
    .clock, .reset, .rd_en, .wr_en, .addr, .wdata, .rdata, .op, .ack, .txd, .rxd
  );

  assign rxd = loop_back ? txd : rxd_drive;

  always #(CLK_PERIOD / 2) clock = ~clock;

  // Taps 16, 14, 13, 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic data_t random_byte();
    data_t b;
    b = '0;
    for (int i = 0; i < 8; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      b = {b[6:0], lfsr_state[0]};
    end
    return b;
  endfunction

  // Expected STATUS byte with tx_full in bit 3
  function automatic data_t status_value(input logic tx_full, input logic tx_empty,
                                         input logic rx_empty, input logic overrun);
    return {4'b0000, tx_full, tx_empty, rx_empty, overrun};
  endfunction

  task automatic check_value(input string name, input data_t actual, input data_t expected);
    if (actual !== expected) begin
      $display("mismatch %s: got 0x%02h, expected 0x%02h", name, actual, expected);
      errors++;
    end
  endtask

  task automatic wait_ack(input string what);
    int n;
    n = 0;
    while (!ack && n < ACK_LIMIT) begin
      @(negedge clock);
      n++;
    end
    if (!ack) begin
      $display("error: no ack for %s", what);
      errors++;
    end
  endtask

  task automatic do_write(input addr_t a, input data_t d);
    @(negedge clock);
    addr  = a;
    wdata = d;
    wr_en = 1'b1;
    @(negedge clock);
    wr_en = 1'b0;
    wait_ack("write");
  endtask

  task automatic do_read(input addr_t a, output data_t d);
    @(negedge clock);
    addr  = a;
    rd_en = 1'b1;
    @(negedge clock);
    rd_en = 1'b0;
    wait_ack("read");
    d = rdata;
  endtask

  task automatic wait_status(input int bit_index, input logic level, input string what);
    data_t s;
    int    n;
    n = 0;
    do begin
      do_read(STATUS, s);
      n++;
    end while (s[bit_index] !== level && n < POLL_LIMIT);
    if (s[bit_index] !== level) begin
      $display("error: timed out waiting for %s", what);
      errors++;
    end
  endtask

  task automatic receive_expected();
    data_t d;
    while (expected_q.size() > 0) begin
      wait_status(RX_EMPTY_BIT, 1'b0, "a received byte");
      do_read(RXDATA, d);
      check_value("rdata", d, expected_q.pop_front());
    end
  endtask

  // 8N1 frame on rxd followed by one idle bit
  task automatic drive_frame(input data_t b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      rxd_drive = frame[i];
      repeat (RX_DIV) @(negedge clock);
    end
    repeat (RX_DIV) @(negedge clock);
  endtask

  initial begin
    clock      = 1'b0;
    reset      = 1'b1;
    rd_en      = 1'b0;
    wr_en      = 1'b0;
    addr       = '0;
    wdata      = '0;
    loop_back  = 1'b1;
    rxd_drive  = 1'b1;
    lfsr_state = 16'd69;
    errors     = 0;
    repeat (8) @(negedge clock);
    reset = 1'b0;

    @(negedge clock);
    if (op || ack || !txd) begin
      $display("error: bus or txd not idle after reset");
      errors++;
    end
    do_read(STATUS, got);
    check_value("status", got, status_value(1'b0, 1'b1, 1'b1, 1'b0));

    do_write(DIVISOR, data_t'(LOOP_DIV));
    do_read(DIVISOR, got);
    check_value("divisor", got, data_t'(LOOP_DIV));

    // Loopback through txd
    for (int i = 0; i < LOOP_BYTES; i++) begin
      got = random_byte();
      expected_q.push_back(got);
      do_write(TXDATA, got);
    end
    receive_expected();

    // First byte to the shifter, four more into the FIFO and two dropped
    do_write(DIVISOR, data_t'(FULL_DIV));
    got = random_byte();
    expected_q.push_back(got);
    do_write(TXDATA, got);
    wait_status(TX_EMPTY_BIT, 1'b1, "the first byte to leave the tx FIFO");
    for (int i = 1; i < FULL_BYTES - 1; i++) begin
      got = random_byte();
      if (i <= `UART_FIFO_DEPTH) expected_q.push_back(got);
      do_write(TXDATA, got);
    end
    do_read(STATUS, got);
    check_value("status.tx_full", data_t'(got[TX_FULL_BIT]), 8'd1);
    // Next frame frees one slot
    wait_status(TX_FULL_BIT, 1'b0, "the tx FIFO to free a slot");
    got = random_byte();
    expected_q.push_back(got);
    do_write(TXDATA, got);
    receive_expected();

    // Five frames into a four-deep rx FIFO
    do_write(DIVISOR, data_t'(RX_DIV));
    loop_back = 1'b0;
    for (int i = 0; i <= `UART_FIFO_DEPTH; i++) begin
      got = random_byte();
      if (i < `UART_FIFO_DEPTH) expected_q.push_back(got);
      drive_frame(got);
    end
    do_read(STATUS, got);
    check_value("status", got, status_value(1'b0, 1'b1, 1'b0, 1'b1));
    do_read(STATUS, got);
    check_value("status", got, status_value(1'b0, 1'b1, 1'b0, 1'b0));
    receive_expected();

    // Low for a quarter bit only
    rxd_drive = 1'b0;
    repeat (RX_DIV / 4) @(negedge clock);
    rxd_drive = 1'b1;
    // Past a whole frame, so a frame started by the glitch would have landed
    repeat (12 * RX_DIV) @(negedge clock);
    do_read(STATUS, got);
    check_value("status", got, status_value(1'b0, 1'b1, 1'b1, 1'b0));
    do_read(RXDATA, got);
    check_value("rdata", got, 8'h00);

    repeat (4) @(negedge clock);
    $display("errors: %0d testbench, %0d assertion", errors, DUT.checks.fail_count);
    if (errors == 0 && DUT.checks.fail_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("error: watchdog timeout after %0d cycles, %0d errors so far",
             WATCHDOG_CYCLES, errors);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

// ==== src.f ====
+incdir+design
design/uart_pkg.sv
design/uart_fifo.sv
design/uart_fsm.sv
design/uart_bank.sv
design/uart_baud_timer.sv
design/uart_phy.sv
design/uart_top.sv
dv/uart_assert.sv
dv/uart_tb.sv
